// ==== hw/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define WORD_W   32          // Data and address
`define REG_A_W  5           // Register index
`define NUM_REGS 32
`define OP_W     6           // Opcode field
`define FN_W     6           // R-type function field
`define IMM_W    21          // Memory immediate field

// Opcodes, bits 31..26 of the instruction
`define OP_RTYPE 6'd0
`define OP_JUMP  6'd2
`define OP_BEQ   6'd4
`define OP_ADDI  6'd8
`define OP_LDB   6'd32       // Byte load
`define OP_LDW   6'd35       // Word load
`define OP_STB   6'd40
`define OP_STW   6'd43

// Function codes, R-type only
`define FN_MUL   6'd24

`endif

// ==== hw/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

    // Widths with a meaning of their own
    typedef logic [`WORD_W-1:0]  word_t;      // Data or address
    typedef logic [`REG_A_W-1:0] reg_addr_t;  // Register file index
    typedef logic [`OP_W-1:0]    opcode_t;
    typedef logic [`FN_W-1:0]    funct_t;

    // Four-phase link state, shared by both ports
    // Receive side: IDLE waits for req, BUSY holds ack until req drops
    // Send side: IDLE -> BUSY with req up -> RETURN with req down, waiting for ack low
    typedef enum logic [1:0] {
        HS_IDLE   = 2'd0,
        HS_BUSY   = 2'd1,
        HS_RETURN = 2'd2
    } hs_state_t;

endpackage

// ==== hw/decode_if.sv ====
// One decoded instruction, fetch side -> issue port
interface decode_if;
    import cpu_pkg::*;

    logic      valid;          // Fetch slot full, fields below are meaningful
    logic      take;           // One-cycle pulse from issue port, moves the item

    word_t     pc;
    opcode_t   op_code;
    funct_t    funct_code;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t dest_reg;
    word_t     rs_data;        // Register file contents this cycle
    word_t     rt_data;
    word_t     mimmediat;      // Sign-extended memory offset
    word_t     jump_addr;

    // Control bits for later stages
    logic      regwrite;
    logic      memtoreg;
    logic      branch;
    logic      memwrite;
    logic      memread;
    logic      byteword;       // 1 word, 0 byte
    logic      alusrc;
    logic      is_jump;
    logic      is_mult;
    logic      illegal;

    modport producer (
        output valid, pc, op_code, funct_code, rs_addr, rt_addr, dest_reg,
               rs_data, rt_data, mimmediat, jump_addr,
               regwrite, memtoreg, branch, memwrite, memread, byteword,
               alusrc, is_jump, is_mult, illegal
    );

    modport consumer (
        input  valid, pc, op_code, funct_code, rs_addr, rt_addr, dest_reg,
               rs_data, rt_data, mimmediat, jump_addr,
               regwrite, memtoreg, branch, memwrite, memread, byteword,
               alusrc, is_jump, is_mult, illegal,
        output take
    );

endinterface

// ==== hw/fetch_port.sv ====
// Receive side of the fetch link plus a one-entry holding slot
module fetch_port (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_req,
    input  cpu_pkg::word_t in_pc,
    input  cpu_pkg::word_t in_instr,
    output logic          in_ack,
    input  logic          take,       // Issue port empties the slot
    output logic          valid,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t instr
);
    import cpu_pkg::*;

    hs_state_t state;
    logic      full;
    logic      latch;                 // Accept a new instruction this edge

    // No new request accepted while the previous one still sits in the slot
    assign latch = (state == HS_IDLE) && in_req && !full;
    assign valid = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= HS_IDLE;
            in_ack <= 1'b0;
            full   <= 1'b0;
        end else begin
            if (take)
                full <= 1'b0;         // Never coincides with latch, full is high here
            case (state)
                HS_IDLE: begin
                    if (latch) begin
                        state  <= HS_BUSY;
                        in_ack <= 1'b1;   // Ack on the same edge as the capture
                        full   <= 1'b1;
                    end
                end
                HS_BUSY: begin
                    // Hold ack until the fetch side lets go of req
                    if (!in_req) begin
                        state  <= HS_IDLE;
                        in_ack <= 1'b0;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    // Holding register
    always_ff @(posedge clk) begin
        if (latch) begin
            pc    <= in_pc;
            instr <= in_instr;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`include "cpu_defs.svh"

// 32 x 32 register file, r0 hardwired to zero
module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data,
    input  logic                wb_en,      // Write-back strobe
    input  cpu_pkg::reg_addr_t  wb_addr,
    input  cpu_pkg::word_t      wb_data
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];

    // Write port, r0 writes dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Read ports are combinational
    // A write in the same cycle only shows up on the next read
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== hw/control_unit.sv ====
`include "cpu_defs.svh"

// Main decoder, opcode and funct to control bits
module control_unit (
    input  cpu_pkg::opcode_t op_code,
    input  cpu_pkg::funct_t  funct_code,
    output logic             regwrite,   // WB writes a register
    output logic             memtoreg,   // WB data from memory
    output logic             branch,
    output logic             memwrite,
    output logic             memread,
    output logic             byteword,   // 1 word access, 0 byte access
    output logic             alusrc,     // ALU operand B from immediate
    output logic             is_jump,
    output logic             is_mult,    // Steer to multiplier pipe
    output logic             illegal
);

    always_comb begin
        regwrite = 1'b0;
        memtoreg = 1'b0;
        branch   = 1'b0;
        memwrite = 1'b0;
        memread  = 1'b0;
        byteword = 1'b0;
        alusrc   = 1'b0;
        is_jump  = 1'b0;
        is_mult  = 1'b0;
        illegal  = 1'b0;
        case (op_code)
            `OP_RTYPE: begin
                regwrite = 1'b1;
                is_mult  = (funct_code == `FN_MUL);
            end
            `OP_ADDI: begin
                regwrite = 1'b1;
                alusrc   = 1'b1;
            end
            `OP_LDW, `OP_LDB: begin
                regwrite = 1'b1;
                memtoreg = 1'b1;
                memread  = 1'b1;
                alusrc   = 1'b1;
                byteword = (op_code == `OP_LDW);   // LDB stays byte
            end
            `OP_STW, `OP_STB: begin
                memwrite = 1'b1;
                alusrc   = 1'b1;
                byteword = (op_code == `OP_STW);
            end
            `OP_BEQ:  branch  = 1'b1;
            `OP_JUMP: is_jump = 1'b1;
            default:  illegal = 1'b1;             // Unknown opcode
        endcase
    end

endmodule

// ==== hw/decode_stage.sv ====
`include "cpu_defs.svh"

// Field split, immediates and destination select, feeds decode_if
module decode_stage (
    input  logic               valid_in,   // Fetch slot full
    input  cpu_pkg::word_t     pc,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::reg_addr_t rs_addr,    // To register file
    output cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::word_t     rs_data,    // From register file
    input  cpu_pkg::word_t     rt_data,
    decode_if.producer         dec
);
    import cpu_pkg::*;

    opcode_t   op_code;
    funct_t    funct_code;
    reg_addr_t rd_addr;
    logic      dest_is_rt;                 // I-type carrying rt as dest

    // Instruction fields
    assign op_code    = instr[`WORD_W-1 -: `OP_W];   // 31..26
    assign rs_addr    = instr[25:21];
    assign rt_addr    = instr[20:16];
    assign rd_addr    = instr[15:11];
    assign funct_code = instr[`FN_W-1:0];            // 5..0

    // Loads and ADDI write rt, everything else carries rd
    // Stores carry rt as dest too, even though they write nothing
    always_comb begin
        case (op_code)
            `OP_LDW, `OP_LDB, `OP_ADDI,
            `OP_STW, `OP_STB:           dest_is_rt = 1'b1;
            default:                    dest_is_rt = 1'b0;
        endcase
    end

    assign dec.valid      = valid_in;
    assign dec.pc         = pc;
    assign dec.op_code    = op_code;
    assign dec.funct_code = funct_code;
    assign dec.rs_addr    = rs_addr;
    assign dec.rt_addr    = rt_addr;
    assign dec.dest_reg   = dest_is_rt ? rt_addr : rd_addr;
    assign dec.rs_data    = rs_data;
    assign dec.rt_data    = rt_data;

    // Memory offset, sign-extended from bit 20
    assign dec.mimmediat  = {{(`WORD_W - `IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};

    // Jump target stays inside the current 256 MB region
    assign dec.jump_addr  = {pc[`WORD_W-1 -: 4], instr[25:0], 2'b00};

    control_unit u_control_unit (
        .op_code    (op_code),
        .funct_code (funct_code),
        .regwrite   (dec.regwrite),
        .memtoreg   (dec.memtoreg),
        .branch     (dec.branch),
        .memwrite   (dec.memwrite),
        .memread    (dec.memread),
        .byteword   (dec.byteword),
        .alusrc     (dec.alusrc),
        .is_jump    (dec.is_jump),
        .is_mult    (dec.is_mult),
        .illegal    (dec.illegal)
    );

endmodule

// ==== hw/issue_port.sv ====
// Stage boundary register and send side of the execute link
module issue_port (
    input  logic               clk,
    input  logic               reset,
    decode_if.consumer         dec,
    output logic               out_req,
    input  logic               out_ack,
    output cpu_pkg::word_t     out_pc,
    output cpu_pkg::opcode_t   out_op_code,
    output cpu_pkg::funct_t    out_funct_code,
    output cpu_pkg::reg_addr_t out_rs_addr,
    output cpu_pkg::reg_addr_t out_rt_addr,
    output cpu_pkg::reg_addr_t out_dest_reg,
    output cpu_pkg::word_t     out_rs_data,
    output cpu_pkg::word_t     out_rt_data,
    output cpu_pkg::word_t     out_mimmediat,
    output cpu_pkg::word_t     out_jump_addr,
    output logic               out_regwrite,
    output logic               out_memtoreg,
    output logic               out_branch,
    output logic               out_memwrite,
    output logic               out_memread,
    output logic               out_byteword,
    output logic               out_alusrc,
    output logic               out_is_jump,
    output logic               out_is_mult,
    output logic               out_illegal
);
    import cpu_pkg::*;

    hs_state_t state;    // Anything but IDLE means a packet is held

    // Pull the next item only when the link is fully back to idle
    assign dec.take = (state == HS_IDLE) && dec.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= HS_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (dec.take) begin
                        state   <= HS_BUSY;
                        out_req <= 1'b1;      // Packet registered on this edge too
                    end
                end
                HS_BUSY: begin
                    if (out_ack) begin
                        state   <= HS_RETURN;
                        out_req <= 1'b0;
                    end
                end
                HS_RETURN: begin
                    if (!out_ack)
                        state <= HS_IDLE;     // Execute has closed the cycle
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    // Packet register, stable from take until the next take
    always_ff @(posedge clk) begin
        if (dec.take) begin
            out_pc         <= dec.pc;
            out_op_code    <= dec.op_code;
            out_funct_code <= dec.funct_code;
            out_rs_addr    <= dec.rs_addr;
            out_rt_addr    <= dec.rt_addr;
            out_dest_reg   <= dec.dest_reg;
            out_rs_data    <= dec.rs_data;
            out_rt_data    <= dec.rt_data;
            out_mimmediat  <= dec.mimmediat;
            out_jump_addr  <= dec.jump_addr;
            out_regwrite   <= dec.regwrite;
            out_memtoreg   <= dec.memtoreg;
            out_branch     <= dec.branch;
            out_memwrite   <= dec.memwrite;
            out_memread    <= dec.memread;
            out_byteword   <= dec.byteword;
            out_alusrc     <= dec.alusrc;
            out_is_jump    <= dec.is_jump;
            out_is_mult    <= dec.is_mult;
            out_illegal    <= dec.illegal;
        end
    end

endmodule

// ==== hw/decode_top.sv ====
// Decode stage, fetch link in, execute link out
module decode_top (
    input  logic               clk,
    input  logic               reset,
    // Fetch link
    input  logic               in_req,
    input  cpu_pkg::word_t     in_pc,
    input  cpu_pkg::word_t     in_instr,
    output logic               in_ack,
    // Write-back port
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,
    // Execute link
    output logic               out_req,
    input  logic               out_ack,
    output cpu_pkg::word_t     out_pc,
    output cpu_pkg::opcode_t   out_op_code,
    output cpu_pkg::funct_t    out_funct_code,
    output cpu_pkg::reg_addr_t out_rs_addr,
    output cpu_pkg::reg_addr_t out_rt_addr,
    output cpu_pkg::reg_addr_t out_dest_reg,
    output cpu_pkg::word_t     out_rs_data,
    output cpu_pkg::word_t     out_rt_data,
    output cpu_pkg::word_t     out_mimmediat,
    output cpu_pkg::word_t     out_jump_addr,
    output logic               out_regwrite,
    output logic               out_memtoreg,
    output logic               out_branch,
    output logic               out_memwrite,
    output logic               out_memread,
    output logic               out_byteword,
    output logic               out_alusrc,
    output logic               out_is_jump,
    output logic               out_is_mult,
    output logic               out_illegal
);
    import cpu_pkg::*;

    logic      fetch_valid;
    word_t     fetch_pc;
    word_t     fetch_instr;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    decode_if dec_bus ();

    fetch_port u_fetch_port (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .in_ack   (in_ack),
        .take     (dec_bus.take),   // Slot empties when issue port takes
        .valid    (fetch_valid),
        .pc       (fetch_pc),
        .instr    (fetch_instr)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    decode_stage u_decode_stage (
        .valid_in (fetch_valid),
        .pc       (fetch_pc),
        .instr    (fetch_instr),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .dec      (dec_bus.producer)
    );

    issue_port u_issue_port (
        .clk            (clk),
        .reset          (reset),
        .dec            (dec_bus.consumer),
        .out_req        (out_req),
        .out_ack        (out_ack),
        .out_pc         (out_pc),
        .out_op_code    (out_op_code),
        .out_funct_code (out_funct_code),
        .out_rs_addr    (out_rs_addr),
        .out_rt_addr    (out_rt_addr),
        .out_dest_reg   (out_dest_reg),
        .out_rs_data    (out_rs_data),
        .out_rt_data    (out_rt_data),
        .out_mimmediat  (out_mimmediat),
        .out_jump_addr  (out_jump_addr),
        .out_regwrite   (out_regwrite),
        .out_memtoreg   (out_memtoreg),
        .out_branch     (out_branch),
        .out_memwrite   (out_memwrite),
        .out_memread    (out_memread),
        .out_byteword   (out_byteword),
        .out_alusrc     (out_alusrc),
        .out_is_jump    (out_is_jump),
        .out_is_mult    (out_is_mult),
        .out_illegal    (out_illegal)
    );

endmodule

// ==== testbench/decode_sva.sv ====
// Protocol checks on the fetch and execute links, bound into decode_top
module decode_sva (
    input logic                clk,
    input logic                reset,
    input logic                in_req,
    input logic                in_ack,
    input cpu_pkg::word_t      in_pc,
    input cpu_pkg::word_t      in_instr,
    input logic                out_req,
    input logic                out_ack,
    input cpu_pkg::word_t      out_pc,
    input cpu_pkg::reg_addr_t  out_dest_reg,
    input cpu_pkg::word_t      out_rs_data,
    input cpu_pkg::word_t      out_rt_data,
    input cpu_pkg::word_t      out_mimmediat,
    input cpu_pkg::word_t      out_jump_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    int fail_count = 0;    // Read by the testbench at the end

    // Fetch side holds PC and instruction for the whole request
    in_data_stable: assert property (@(posedge clk) disable iff (reset)
        in_req && $past(in_req) |-> $stable({in_pc, in_instr}))
        else begin
            $error("fetch data changed while in_req was high");
            fail_count++;
        end

    // Packet frozen while out_req is up
    out_data_stable: assert property (@(posedge clk) disable iff (reset)
        out_req && $past(out_req) |-> $stable({out_pc, out_dest_reg, out_rs_data,
                                               out_rt_data, out_mimmediat, out_jump_addr}))
        else begin
            $error("execute packet changed while out_req was high");
            fail_count++;
        end

    // Ack edge sampled one cycle late, so req may be seen in either cycle
    in_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> (in_req || $past(in_req)))
        else begin
            $error("in_ack rose without in_req");
            fail_count++;
        end

    out_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(out_ack) |-> (out_req || $past(out_req)))
        else begin
            $error("out_ack rose without out_req");
            fail_count++;
        end

    // Req only drops once the matching ack has been given
    in_req_held: assert property (@(posedge clk) disable iff (reset)
        $fell(in_req) |-> (in_ack || $past(in_ack)))
        else begin
            $error("in_req fell before in_ack");
            fail_count++;
        end

    out_req_held: assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> (out_ack || $past(out_ack)))
        else begin
            $error("out_req fell before out_ack");
            fail_count++;
        end

    // Synchronous reset, outputs quiet one edge in
    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !in_ack && !out_req)
        else begin
            $error("in_ack or out_req high during reset");
            fail_count++;
        end

endmodule

bind decode_top decode_sva u_decode_sva (
    .clk           (clk),
    .reset         (reset),
    .in_req        (in_req),
    .in_ack        (in_ack),
    .in_pc         (in_pc),
    .in_instr      (in_instr),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .out_pc        (out_pc),
    .out_dest_reg  (out_dest_reg),
    .out_rs_data   (out_rs_data),
    .out_rt_data   (out_rt_data),
    .out_mimmediat (out_mimmediat),
    .out_jump_addr (out_jump_addr)
);

// ==== testbench/tb_decode_top.sv ====
`include "cpu_defs.svh"

module tb_decode_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int TIMEOUT = 200;    // Cycles allowed per wait
    localparam int N_BURST = 40;

    // Expected packet, control bits ordered as on the DUT ports
    typedef struct packed {
        word_t     pc;
        opcode_t   op;
        funct_t    fn;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     rs_data;
        word_t     rt_data;
        word_t     mimm;
        word_t     jump;
        logic [9:0] ctl;
    } exp_pkt_t;

    logic      clk;
    logic      reset;
    logic      in_req;
    word_t     in_pc;
    word_t     in_instr;
    logic      in_ack;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      out_req;
    logic      out_ack;
    word_t     out_pc, out_rs_data, out_rt_data, out_mimmediat, out_jump_addr;
    opcode_t   out_op_code;
    funct_t    out_funct_code;
    reg_addr_t out_rs_addr, out_rt_addr, out_dest_reg;
    logic      out_regwrite, out_memtoreg, out_branch, out_memwrite, out_memread;
    logic      out_byteword, out_alusrc, out_is_jump, out_is_mult, out_illegal;

    integer   seed = 32'h39f34521;
    int       errors = 0;
    int       checks = 0;
    int       acc_cnt = 0;        // in_ack rises seen
    int       rise_cnt = 0;       // out_req rises seen
    logic     prev_in_ack;
    logic     prev_out_req;
    word_t    model_regs [`NUM_REGS];
    exp_pkt_t exp_q [$];

    decode_top u_decode_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Control bits per opcode, from the decode table
    function automatic logic [9:0] exp_ctl(input opcode_t op, input funct_t fn);
        case (op)
            `OP_RTYPE: return (fn == `FN_MUL) ? 10'b1000000010 : 10'b1000000000;
            `OP_ADDI:  return 10'b1000001000;
            `OP_LDW:   return 10'b1100111000;
            `OP_LDB:   return 10'b1100101000;    // Byte, byteword clear
            `OP_STW:   return 10'b0001011000;
            `OP_STB:   return 10'b0001001000;
            `OP_BEQ:   return 10'b0010000000;
            `OP_JUMP:  return 10'b0000000100;
            default:   return 10'b0000000001;    // Only illegal
        endcase
    endfunction

    function automatic exp_pkt_t predict(input word_t pc, input word_t instr);
        exp_pkt_t p;
        p.pc = pc;
        p.op = instr[31:26];
        p.fn = instr[5:0];
        p.rs = instr[25:21];
        p.rt = instr[20:16];
        if (p.op == `OP_LDW || p.op == `OP_LDB || p.op == `OP_ADDI)
            p.dest = p.rt;
        else if (p.op == `OP_STW || p.op == `OP_STB)
            p.dest = p.rt;                        // Stores carry rt as well
        else
            p.dest = instr[15:11];
        p.rs_data = model_regs[p.rs];
        p.rt_data = model_regs[p.rt];
        p.mimm = {11'b0, instr[20:0]};
        if (instr[20])
            p.mimm[31:21] = '1;                   // Negative offset
        p.jump = {pc[31:28], instr[25:0], 2'b00};
        p.ctl  = exp_ctl(p.op, p.fn);
        return p;
    endfunction

    // Listed opcodes plus a few random ones, now and then a zero rs
    function automatic word_t rand_instr();
        word_t   w;
        int      sel;
        opcode_t op;
        w   = $random(seed);
        sel = $unsigned($random(seed)) % 11;
        case (sel)
            0: op = `OP_RTYPE;
            1: op = `OP_JUMP;
            2: op = `OP_BEQ;
            3: op = `OP_ADDI;
            4: op = `OP_LDW;
            5: op = `OP_LDB;
            6: op = `OP_STW;
            7: op = `OP_STB;
            default: op = $random(seed);          // Mostly unlisted
        endcase
        w[31:26] = op;
        if (op == `OP_RTYPE && w[6])
            w[5:0] = `FN_MUL;
        if (($random(seed) & 3) == 0)
            w[25:21] = '0;                        // r0 read
        return w;
    endfunction

    task automatic print_counts();
        $display("Checks: %0d, value errors: %0d, protocol assertion failures: %0d",
                 checks, errors, u_decode_top.u_decode_sva.fail_count);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_in_ack(input logic level);
        int waited;
        waited = 0;
        while (in_ack !== level) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                abort_run("Timeout: in_ack did not reach the expected level");
        end
    endtask

    task automatic wait_out_req(input logic level);
        int waited;
        waited = 0;
        while (out_req !== level) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                abort_run("Timeout: out_req did not reach the expected level");
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        wb_en   = 1'b1;
        wb_addr = a;
        wb_data = d;
        @(negedge clk);
        wb_en = 1'b0;
        if (a != '0)
            model_regs[a] = d;                    // r0 write is dropped
    endtask

    // One four-phase transfer on the fetch link
    task automatic send_instr(input word_t pc, input word_t instr);
        in_req   = 1'b1;
        in_pc    = pc;
        in_instr = instr;
        wait_in_ack(1'b1);
        exp_q.push_back(predict(pc, instr));
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic feed_burst(input int n);
        word_t pc;
        int    gap;
        for (int k = 0; k < n; k++) begin
            pc = $random(seed);
            pc[1:0] = 2'b00;
            send_instr(pc, rand_instr());
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic check_packet();
        exp_pkt_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t ns: packet on the execute link with nothing outstanding",
                     $time);
        end else begin
            e = exp_q.pop_front();
            check_field("out_pc", out_pc, e.pc);
            check_field("out_op_code", out_op_code, e.op);
            check_field("out_funct_code", out_funct_code, e.fn);
            check_field("out_rs_addr", out_rs_addr, e.rs);
            check_field("out_rt_addr", out_rt_addr, e.rt);
            check_field("out_dest_reg", out_dest_reg, e.dest);
            check_field("out_rs_data", out_rs_data, e.rs_data);
            check_field("out_rt_data", out_rt_data, e.rt_data);
            check_field("out_mimmediat", out_mimmediat, e.mimm);
            check_field("out_jump_addr", out_jump_addr, e.jump);
            check_field("out_regwrite", out_regwrite, e.ctl[9]);
            check_field("out_memtoreg", out_memtoreg, e.ctl[8]);
            check_field("out_branch", out_branch, e.ctl[7]);
            check_field("out_memwrite", out_memwrite, e.ctl[6]);
            check_field("out_memread", out_memread, e.ctl[5]);
            check_field("out_byteword", out_byteword, e.ctl[4]);
            check_field("out_alusrc", out_alusrc, e.ctl[3]);
            check_field("out_is_jump", out_is_jump, e.ctl[2]);
            check_field("out_is_mult", out_is_mult, e.ctl[1]);
            check_field("out_illegal", out_illegal, e.ctl[0]);
        end
    endtask

    // Execute side, random ack delay for back-pressure
    task automatic drain_burst(input int n);
        int delay;
        for (int k = 0; k < n; k++) begin
            wait_out_req(1'b1);
            check_packet();
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_out_req(1'b0);
            out_ack = 1'b0;
        end
    endtask

    task automatic run_burst(input int n);
        fork
            feed_burst(n);
            drain_burst(n);
        join
    endtask

    // Fetch slot holds one item, so accepted minus issued never passes 1
    always @(negedge clk) begin
        if (reset) begin
            prev_in_ack  = 1'b0;
            prev_out_req = 1'b0;
        end else begin
            if (in_ack && !prev_in_ack)
                acc_cnt++;
            if (out_req && !prev_out_req)
                rise_cnt++;
            prev_in_ack  = in_ack;
            prev_out_req = out_req;
            assert (acc_cnt - rise_cnt <= 1) else begin
                errors++;
                $display("Error at %0t ns: new instruction acknowledged while slot was full",
                         $time);
            end
        end
    end

    initial begin
        reset    = 1'b1;
        in_req   = 1'b0;
        in_pc    = '0;
        in_instr = '0;
        wb_en    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        out_ack  = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_field("in_ack", in_ack, 1'b0);
        check_field("out_req", out_req, 1'b0);

        run_burst(8);                              // Register file still all zero

        // Known value in every register, r0 included
        for (int i = 0; i < `NUM_REGS; i++)
            write_reg(i, 32'h5a5a_0000 + i * 32'h0104_0811);
        run_burst(N_BURST);

        // A few rewrites between bursts
        for (int r = 0; r < 4; r++) begin
            repeat (4) write_reg($random(seed), $random(seed));
            run_burst(N_BURST);
        end

        if (exp_q.size() != 0) begin
            errors++;
            $display("Error: %0d expected packets never came out", exp_q.size());
        end
        if (acc_cnt != rise_cnt) begin
            errors++;
            $display("Error: %0d instructions accepted but %0d packets issued",
                     acc_cnt, rise_cnt);
        end

        print_counts();
        if (errors == 0 && u_decode_top.u_decode_sva.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/decode_if.sv
hw/fetch_port.sv
hw/reg_file.sv
hw/control_unit.sv
hw/decode_stage.sv
hw/issue_port.sv
hw/decode_top.sv
testbench/decode_sva.sv
testbench/tb_decode_top.sv
